// File: huff_top.f
hdl/huff_pkg.sv
hdl/htree_ram.sv
hdl/cb_walker.sv
hdl/cb_table.sv
hdl/huff_encoder.sv
hdl/huff_top.sv
testbench/huff_checker.sv
testbench/huff_tb.sv

// File: testbench/huff_testdata.txt
# N addr left right loads a node, children in 9-bit hex (1xx sum node, 180 empty, else a char)
# S starts the walk, G max random gap, Y sym [count], F flushes, E ends a test with its name
N 00 101 102
N 01 103 104
N 02 105 106
N 03 041 042
N 04 043 044
N 05 045 046
N 06 047 048
S
Y 41 5
Y 48 7
Y 43 3
Y 46 2
F
F
E balanced_flush
N 00 061 101
N 01 062 102
N 02 063 103
N 03 064 104
N 04 065 105
N 05 066 106
N 06 067 107
N 07 068 108
N 08 069 109
N 09 06a 10a
N 0a 06b 10b
N 0b 06c 10c
N 0c 06d 10d
N 0d 06e 10e
N 0e 06f 070
S
G 3
Y 70 3
Y 61 4
Y 6f 2
Y 5a 1
Y 68 3
G 0
F
E skewed_miss
N 00 030 180
S
Y 30 32
F
E single_leaf
N 00 101 043
N 01 041 05a
S
Y 41 5
Y 48 7
Y 43 3
Y 46 2
F
E reload

// File: testbench/huff_tb.sv
`timescale 1ns/1ps
module huff_tb import huff_pkg::*; ();

  localparam int WALK_CYCLES = 6 * (2 ** NODE_AW); // each node visited twice, 3 cycles a visit

  logic               clk;
  logic               rst;
  logic               node_we;
  logic [NODE_AW-1:0] node_addr;
  node_t              node_data;
  logic               start;
  logic               sym_valid;
  logic [7:0]         sym;
  logic               flush;
  logic               cb_ready;
  logic [8:0]         leaf_count;
  logic               word_valid;
  enc_word_t          word_out;
  logic               sym_miss;
  int                 checks;
  int                 errors;
  int                 tb_errors;
  int                 limit;
  int                 gap_max; // largest random idle gap after a symbol

  huff_top dut_i (
    .clk        (clk),
    .rst        (rst),
    .node_we    (node_we),
    .node_addr  (node_addr),
    .node_data  (node_data),
    .start      (start),
    .sym_valid  (sym_valid),
    .sym        (sym),
    .flush      (flush),
    .cb_ready   (cb_ready),
    .leaf_count (leaf_count),
    .word_valid (word_valid),
    .word_out   (word_out),
    .sym_miss   (sym_miss)
  );

  huff_checker check_i (
    .clk        (clk),
    .rst        (rst),
    .node_we    (node_we),
    .node_addr  (node_addr),
    .node_data  (node_data),
    .start      (start),
    .sym_valid  (sym_valid),
    .sym        (sym),
    .flush      (flush),
    .cb_ready   (cb_ready),
    .leaf_count (leaf_count),
    .word_valid (word_valid),
    .word_out   (word_out),
    .sym_miss   (sym_miss),
    .checks     (checks),
    .errors     (errors)
  );

  always #2 clk = ~clk; // 4 ns period

  // move to 1 ns past the next rising edge and drop every pulse
  task automatic tick();
    @(posedge clk);
    #1;
    node_we   = 1'b0;
    start     = 1'b0;
    sym_valid = 1'b0;
    flush     = 1'b0;
  endtask

  task automatic load_node(input int a, input int l, input int r);
    tick();
    node_we   = 1'b1;
    node_addr = a[NODE_AW-1:0];
    node_data = {l[8:0], r[8:0]};
  endtask

  task automatic start_walk();
    int waited;
    waited = 0;
    tick();
    start = 1'b1;
    tick();
    while (!cb_ready && waited < WALK_CYCLES) begin
      tick();
      waited++;
    end
    if (!cb_ready) begin
      $display("walk did not finish, cb_ready stayed low for %0d cycles", waited);
      tb_errors++;
    end
  endtask

  task automatic send_symbols(input int s, input int n);
    for (int i = 0; i < n; i++) begin
      tick();
      sym_valid = 1'b1;
      sym       = s[7:0];
      if (gap_max > 0) begin
        repeat ($urandom % (gap_max + 1)) tick();
      end
    end
  endtask

  task automatic flush_stream();
    repeat (3) tick(); // keeps flush at least 2 cycles behind the last symbol
    flush = 1'b1;
  endtask

  initial begin
    wait (limit > 0);
    repeat (limit) @(posedge clk);
    $display("timeout, the run did not finish within %0d cycles", limit);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin : main
    int    fd;
    int    lines;
    int    n_args;
    int    a;
    int    l;
    int    r;
    int    n;
    int    tests;
    int    passed;
    int    err_mark;
    string line;
    string cmd;
    string name;
    clk       = 1'b0;
    rst       = 1'b1;
    node_we   = 1'b0;
    node_addr = '0;
    node_data = '0;
    start     = 1'b0;
    sym_valid = 1'b0;
    sym       = '0;
    flush     = 1'b0;
    tb_errors = 0;
    gap_max   = 0;
    lines     = 0;
    tests     = 0;
    passed    = 0;
    err_mark  = 0;
    void'($urandom(49502));
    fd = $fopen("testbench/huff_testdata.txt", "r");
    if (fd == 0) begin
      $display("could not open testbench/huff_testdata.txt");
      tb_errors++;
    end else begin
      while ($fgets(line, fd) > 0) begin
        lines++;
      end
      $fclose(fd);
      fd = $fopen("testbench/huff_testdata.txt", "r");
    end
    limit = 200 * lines + 3 * (2 ** NODE_AW);
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    while (fd != 0 && $fgets(line, fd) > 0) begin
      n_args = $sscanf(line, "%s", cmd);
      if (n_args == 1 && line[0] != "#") begin
        if (cmd == "N") begin
          n_args = $sscanf(line, "%s %h %h %h", cmd, a, l, r);
          load_node(a, l, r);
        end else if (cmd == "S") begin
          start_walk();
        end else if (cmd == "G") begin
          n_args = $sscanf(line, "%s %d", cmd, gap_max);
        end else if (cmd == "Y") begin
          n_args = $sscanf(line, "%s %h %d", cmd, a, n);
          send_symbols(a, (n_args < 3) ? 1 : n);
        end else if (cmd == "F") begin
          flush_stream();
        end else if (cmd == "E") begin
          n_args = $sscanf(line, "%s %s", cmd, name);
          repeat (4) tick(); // let the last words drain
          tests++;
          if (errors + tb_errors == err_mark) begin
            passed++;
            $display("test %s: passed", name);
          end else begin
            $display("test %s: failed with %0d errors", name, errors + tb_errors - err_mark);
          end
          err_mark = errors + tb_errors;
        end
      end
    end
    $display("%0d tests, %0d passed, %0d failed, %0d checks, %0d errors",
             tests, passed, tests - passed, checks, errors + tb_errors);
    if (errors + tb_errors == 0 && tests > 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: testbench/huff_checker.sv
`timescale 1ns/1ps
module huff_checker import huff_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  logic               node_we,
  input  logic [NODE_AW-1:0] node_addr,
  input  node_t              node_data,
  input  logic               start,
  input  logic               sym_valid,
  input  logic [7:0]         sym,
  input  logic               flush,
  input  logic               cb_ready,
  input  logic [8:0]         leaf_count,
  input  logic               word_valid,
  input  enc_word_t          word_out,
  input  logic               sym_miss,
  output int                 checks,
  output int                 errors
);

  node_t             tree [2**NODE_AW]; // copy of every node the controller loaded
  logic [CODE_W-1:0] exp_code [256];
  int                exp_len [256];     // zero marks a symbol with no code
  int                exp_leaves;
  bit                bits [$];          // pending stream bits with the oldest first
  bit                want_word [3];     // slot 0 is due at the current falling edge
  bit                want_miss [3];
  enc_word_t         want_data [3];
  logic              ready_exp;         // codebook finished and not yet restarted
  logic              start_q;

  initial begin
    checks    = 0;
    errors    = 0;
    ready_exp = 1'b0;
    start_q   = 1'b0;
    for (int i = 0; i < 3; i++) begin
      want_word[i] = 1'b0;
      want_miss[i] = 1'b0;
    end
  end

  task automatic report_error(input string msg);
    $display("Fail at %0t ns: %s", $time, msg);
    errors++;
  endtask

  // walks the loaded tree breadth first where left adds a 0 and right adds a 1
  task automatic build_codebook();
    int                q_idx [$];
    logic [CODE_W-1:0] q_code [$];
    int                q_len [$];
    int                idx;
    int                len;
    logic [CODE_W-1:0] code;
    child_t            c;
    exp_leaves = 0;
    for (int s = 0; s < 256; s++) begin
      exp_len[s] = 0;
    end
    q_idx.push_back(0);
    q_code.push_back('0);
    q_len.push_back(0);
    while (q_idx.size() > 0) begin
      idx  = q_idx.pop_front();
      code = q_code.pop_front();
      len  = q_len.pop_front();
      for (int b = 0; b < 2; b++) begin
        c = (b == 1) ? tree[idx].right : tree[idx].left;
        if (c != NULL_CHILD) begin
          if (c.link.is_sum) begin
            q_idx.push_back(int'(c.link.idx));
            q_code.push_back((code << 1) | CODE_W'(b));
            q_len.push_back(len + 1);
          end else begin
            exp_code[c.leaf.ch] = (code << 1) | CODE_W'(b);
            exp_len[c.leaf.ch]  = len + 1; // a lone root leaf ends up as code 0 of length 1
            exp_leaves++;
          end
        end
      end
    end
  endtask

  task automatic take_symbol(input logic [7:0] s);
    enc_word_t w;
    if (exp_len[s] == 0) begin
      want_miss[2] = 1'b1;
    end else begin
      for (int i = exp_len[s] - 1; i >= 0; i--) begin
        bits.push_back(exp_code[s][i]); // msb of the code goes out first
      end
      if (bits.size() >= WORD_W) begin
        w.count = 6'(WORD_W);
        for (int i = WORD_W - 1; i >= 0; i--) begin
          w.data[i] = bits.pop_front();
        end
        want_word[2] = 1'b1;
        want_data[2] = w;
      end
    end
  endtask

  task automatic take_flush();
    enc_word_t w;
    if (bits.size() > 0) begin
      w.data  = '0;
      w.count = 6'(bits.size());
      for (int i = 0; i < bits.size(); i++) begin
        w.data[WORD_W-1-i] = bits[i];
      end
      bits.delete();
      want_word[1] = 1'b1;
      want_data[1] = w;
    end
  endtask

  always @(negedge clk) begin
    if (!rst) begin
      for (int i = 0; i < 2; i++) begin
        want_word[i] = want_word[i+1];
        want_miss[i] = want_miss[i+1];
        want_data[i] = want_data[i+1];
      end
      want_word[2] = 1'b0;
      want_miss[2] = 1'b0;
      if (want_word[0] || word_valid) begin
        checks++;
        if (word_valid !== want_word[0]) begin
          report_error($sformatf("word_valid is %b, expected %b", word_valid, want_word[0]));
        end else if (word_out !== want_data[0]) begin
          report_error($sformatf("word %h count %0d, expected %h count %0d", word_out.data,
                                 word_out.count, want_data[0].data, want_data[0].count));
        end
      end
      if (want_miss[0] || sym_miss) begin
        checks++;
        if (sym_miss !== want_miss[0]) begin
          report_error($sformatf("sym_miss is %b, expected %b", sym_miss, want_miss[0]));
        end
      end
      if (start_q) begin
        checks++;
        if (cb_ready !== 1'b0) begin
          report_error("cb_ready still high in the cycle after start");
        end
      end else if (ready_exp) begin
        if (cb_ready !== 1'b1) begin
          report_error("cb_ready fell before the next start");
        end
      end else if (cb_ready === 1'b1) begin
        checks++;
        ready_exp = 1'b1; // walk finished so symbols are encoded from here on
        if (leaf_count !== 9'(exp_leaves)) begin
          report_error($sformatf("leaf_count %0d, expected %0d", leaf_count, exp_leaves));
        end
      end
      if (node_we) begin
        tree[node_addr] = node_data;
      end
      if (start) begin
        build_codebook();
        ready_exp = 1'b0;
      end
      if (sym_valid && ready_exp) begin
        take_symbol(sym);
      end
      if (flush) begin
        take_flush();
      end
      start_q = start;
    end
  end

endmodule

// File: hdl/huff_top.sv
`timescale 1ns/1ps
module huff_top import huff_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  logic               node_we,
  input  logic [NODE_AW-1:0] node_addr,
  input  node_t              node_data,
  input  logic               start,
  input  logic               sym_valid,
  input  logic [7:0]         sym,
  input  logic               flush,
  output logic               cb_ready,
  output logic [8:0]         leaf_count,
  output logic               word_valid,
  output enc_word_t          word_out,
  output logic               sym_miss
);

  logic [NODE_AW-1:0] rd_addr;
  node_t              rd_node;
  logic               cb_we;
  logic [7:0]         cb_sym;
  cb_entry_t          cb_entry;
  logic [7:0]         lk_sym;
  cb_entry_t          lk_entry;
  logic               lk_valid;

  // tree is loaded straight from the controller while the walker sits idle
  htree_ram tree_i (
    .clk   (clk),
    .we    (node_we),
    .waddr (node_addr),
    .wdata (node_data),
    .raddr (rd_addr),
    .rdata (rd_node)
  );

  cb_walker walker_i (
    .clk        (clk),
    .rst        (rst),
    .start      (start),
    .rd_addr    (rd_addr),
    .rd_node    (rd_node),
    .cb_we      (cb_we),
    .cb_sym     (cb_sym),
    .cb_entry   (cb_entry),
    .done       (cb_ready),
    .leaf_count (leaf_count)
  );

  cb_table table_i (
    .clk    (clk),
    .rst    (rst),
    .clear  (start), // old codes vanish as soon as a new walk begins
    .we     (cb_we),
    .wsym   (cb_sym),
    .wentry (cb_entry),
    .rsym   (lk_sym),
    .rentry (lk_entry),
    .rvalid (lk_valid)
  );

  huff_encoder enc_i (
    .clk        (clk),
    .rst        (rst),
    .enable     (cb_ready),
    .sym_valid  (sym_valid),
    .sym        (sym),
    .flush      (flush),
    .lk_sym     (lk_sym),
    .lk_entry   (lk_entry),
    .lk_valid   (lk_valid),
    .word_valid (word_valid),
    .word_out   (word_out),
    .sym_miss   (sym_miss)
  );

endmodule

// File: hdl/huff_encoder.sv
`timescale 1ns/1ps
module huff_encoder import huff_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       enable,
  input  logic       sym_valid,
  input  logic [7:0] sym,
  input  logic       flush,
  output logic [7:0] lk_sym,
  input  cb_entry_t  lk_entry,
  input  logic       lk_valid,
  output logic       word_valid,
  output enc_word_t  word_out,
  output logic       sym_miss
);

  logic             s1_valid;   // lookup in flight, entry arrives this cycle
  logic [ACC_W-1:0] acc;        // pending bits, right aligned
  logic [5:0]       cnt;        // number of pending bits
  logic [ACC_W-1:0] acc_n;
  logic [5:0]       cnt_n;
  logic             hit;
  logic             full_word;
  logic             flush_word;
  logic [WORD_W-1:0] full_data;
  logic [WORD_W-1:0] flush_data;

  assign lk_sym = sym; // the table registers the address in the same edge as stage 1

  always_comb begin
    acc_n      = (acc << lk_entry.len) | ACC_W'(lk_entry.code);
    cnt_n      = cnt + 6'(lk_entry.len);
    hit        = s1_valid && lk_valid;
    full_word  = hit && (cnt_n >= 6'(WORD_W));
    flush_word = flush && !s1_valid && (cnt != '0);
    full_data  = WORD_W'(acc_n >> (cnt_n - 6'(WORD_W))); // oldest 32 bits
    flush_data = WORD_W'(acc << (6'(WORD_W) - cnt));     // left justify, zero fill
  end

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      s1_valid   <= 1'b0;
      cnt        <= '0;
      word_valid <= 1'b0;
      sym_miss   <= 1'b0;
    end else begin
      s1_valid   <= sym_valid && enable;
      word_valid <= full_word || flush_word;
      sym_miss   <= s1_valid && !lk_valid; // a miss adds nothing to the stream
      if (hit) begin
        cnt <= full_word ? cnt_n - 6'(WORD_W) : cnt_n;
      end else if (flush) begin
        cnt <= '0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (hit) begin
      acc <= acc_n; // bits above cnt are stale and never read
    end else if (flush) begin
      acc <= '0;
    end
    if (full_word) begin
      word_out.data  <= full_data;
      word_out.count <= 6'(WORD_W);
    end else if (flush_word) begin
      word_out.data  <= flush_data;
      word_out.count <= cnt;
    end
  end

endmodule

// File: hdl/cb_table.sv
`timescale 1ns/1ps
module cb_table import huff_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       clear,
  input  logic       we,
  input  logic [7:0] wsym,
  input  cb_entry_t  wentry,
  input  logic [7:0] rsym,
  output cb_entry_t  rentry,
  output logic       rvalid
);

  cb_entry_t    mem [256]; // one code per byte value
  logic [255:0] valid;     // set once the walker has written that symbol

  always_ff @(posedge clk) begin
    if (we) begin
      mem[wsym] <= wentry;
    end
    rentry <= mem[rsym];
  end

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      valid  <= '0;
      rvalid <= 1'b0;
    end else begin
      if (clear) begin
        valid <= '0; // a new walk forgets every old code
      end else if (we) begin
        valid[wsym] <= 1'b1;
      end
      rvalid <= valid[rsym]; // lines up with rentry
    end
  end

endmodule

// File: hdl/cb_walker.sv
`timescale 1ns/1ps
module cb_walker import huff_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  logic               start,
  output logic [NODE_AW-1:0] rd_addr,
  input  node_t              rd_node,
  output logic               cb_we,
  output logic [7:0]         cb_sym,
  output cb_entry_t          cb_entry,
  output logic               done,
  output logic [8:0]         leaf_count
);

  typedef enum logic [2:0] {
    IDLE,
    FETCH,
    WAIT,
    LEFT,
    RIGHT,
    EMIT,
    POP,
    DONE
  } walk_state_t;

  walk_state_t        state;
  logic [NODE_AW-1:0] cur;                      // node being visited
  logic [CODE_W-1:0]  path;                     // branch bits so far, newest in the lsb
  logic [LEN_W-1:0]   depth;                    // path length, also the stack pointer
  logic [NODE_AW-1:0] stack [MAX_DEPTH];        // parents of cur, one per level
  logic [MAX_DEPTH-1:0] rt;                     // right branch already taken at that level
  logic               emit_right;               // the pending entry came from a right child

  logic               act;
  logic               side;
  child_t             child;
  logic               is_null;
  logic               push;
  logic               leaf_hit;
  logic               anc_right;
  logic [LEN_W-1:0]   depth_m1;

  assign rd_addr  = cur; // address is held for the whole visit
  assign done     = (state == DONE);
  assign act      = (state == LEFT) || (state == RIGHT);
  assign side     = (state == RIGHT); // also the bit appended for this child
  assign child    = side ? rd_node.right : rd_node.left;
  assign is_null  = (child == NULL_CHILD);
  assign push     = act && !is_null && child.link.is_sum;
  assign leaf_hit = act && !is_null && !child.leaf.is_sum;
  assign depth_m1 = depth - 1'b1;

  // true when every level above cur has already gone right, so nothing is left to visit
  always_comb begin
    anc_right = 1'b1;
    for (int i = 0; i < MAX_DEPTH; i++) begin
      if (i < int'(depth) && !rt[i]) begin
        anc_right = 1'b0;
      end
    end
  end

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      state      <= IDLE;
      cur        <= '0;
      path       <= '0;
      depth      <= '0;
      rt         <= '0;
      emit_right <= 1'b0;
      cb_we      <= 1'b0;
      leaf_count <= '0;
    end else begin
      cb_we <= 1'b0;
      case (state)
        IDLE, DONE: begin
          if (start) begin
            cur        <= '0; // walk always begins at the root
            path       <= '0;
            depth      <= '0;
            rt         <= '0;
            leaf_count <= '0;
            state      <= FETCH;
          end
        end
        FETCH: state <= WAIT;
        WAIT:  state <= rt[depth] ? RIGHT : LEFT; // revisited parents resume on the right
        LEFT, RIGHT: begin
          if (side) begin
            rt[depth] <= 1'b1;
          end
          if (is_null) begin
            state <= side ? POP : RIGHT; // empty child is skipped
          end else if (push) begin
            path           <= {path[CODE_W-2:0], side};
            depth          <= depth + 1'b1;
            rt[depth + 1'b1] <= 1'b0; // fresh level for the child
            cur            <= child.link.idx;
            state          <= FETCH;
          end else begin
            cb_we      <= 1'b1;
            emit_right <= side;
            state      <= EMIT;
          end
        end
        EMIT: begin
          leaf_count <= leaf_count + 1'b1;
          // finishing here lets cb_ready follow the last write directly
          if (anc_right && (emit_right || rd_node.right == NULL_CHILD)) begin
            state <= DONE;
          end else if (emit_right) begin
            state <= POP;
          end else begin
            state <= RIGHT;
          end
        end
        POP: begin
          if (depth == '0) begin
            state <= DONE; // root finished on both sides
          end else begin
            depth <= depth_m1;
            path  <= path >> 1;
            cur   <= stack[depth_m1];
            if (!rt[depth_m1]) begin
              rt[depth_m1] <= 1'b1;
              state        <= FETCH; // parent still owes its right branch
            end
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      stack[depth] <= cur;
    end
    if (leaf_hit) begin
      cb_sym        <= child.leaf.ch;
      cb_entry.code <= {path[CODE_W-2:0], side};
      cb_entry.len  <= depth + 1'b1; // a lone leaf at the root gets code 0 of length 1
    end
  end

endmodule

// File: hdl/htree_ram.sv
`timescale 1ns/1ps
module htree_ram import huff_pkg::*; (
  input  logic               clk,
  input  logic               we,
  input  logic [NODE_AW-1:0] waddr,
  input  node_t              wdata,
  input  logic [NODE_AW-1:0] raddr,
  output node_t              rdata
);

  localparam int DEPTH = 2 ** NODE_AW;

  node_t mem [DEPTH]; // contents are whatever the controller loaded last

  // load port, one node per strobe from the external controller
  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // registered read, so data for an address shows up one cycle later
  always_ff @(posedge clk) begin
    rdata <= mem[raddr]; // the walker holds raddr steady while it uses the node
  end

endmodule

// File: hdl/huff_pkg.sv
package huff_pkg;

  localparam int NODE_AW   = 7;                  // up to 128 tree nodes, node 0 is the root
  localparam int MAX_DEPTH = 15;                 // longest code, also the walker stack depth
  localparam int CODE_W    = 15;                 // code field, right aligned
  localparam int LEN_W     = 4;                  // code length field
  localparam int WORD_W    = 32;                 // packed output word
  localparam int ACC_W     = WORD_W + MAX_DEPTH; // worst case pending bits plus one code

  localparam logic [8:0] NULL_CHILD = 9'h180;    // sum flag and bit 7 both set means no child

  // a child seen as a leaf carries the character itself
  typedef struct packed {
    logic       is_sum;
    logic [7:0] ch;
  } leaf_view_t;

  // a child seen as a link points to another tree node
  typedef struct packed {
    logic               is_sum;
    logic               spare;
    logic [NODE_AW-1:0] idx;
  } link_view_t;

  typedef union packed {
    leaf_view_t leaf;
    link_view_t link;
  } child_t;

  typedef struct packed {
    child_t left;  // branch taken with a 0
    child_t right; // branch taken with a 1
  } node_t;

  typedef struct packed {
    logic [CODE_W-1:0] code; // only the low len bits are meaningful
    logic [LEN_W-1:0]  len;
  } cb_entry_t;

  typedef struct packed {
    logic [WORD_W-1:0] data;  // left justified, first code bit in the msb
    logic [5:0]        count; // number of valid bits in data
  } enc_word_t;

endpackage
